/* design/spi_cmd_pkg.sv */
package spi_cmd_pkg;

  // ******************************
  // Field widths
  // ******************************

  localparam int ADDR_W = 3;                      // Eight registers.
  localparam int DATA_W = 8;
  localparam int CMD_W  = 1 + ADDR_W + DATA_W;    // 12 bits on the wire.
  localparam int READ_W = 8;

  // Encoding of the direction bit in command bit 11.
  localparam logic CMD_WRITE = 1'b1;
  localparam logic CMD_READ  = 1'b0;

  // ******************************
  // Decoded command
  // ******************************

  // Field order matches the wire order, MSB first.
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } cmd_t;

endpackage

/* design/spi_bus_pkg.sv */
package spi_bus_pkg;

  // ******************************
  // Divider to engine
  // ******************************

  // One-cycle pulses that mark the clk cycle before sclk changes.
  typedef struct packed {
    logic rise;
    logic fall;
  } sclk_tick_t;

  // ******************************
  // Pin bundle
  // ******************************

  typedef struct packed {
    logic sclk;
    logic cs;                                     // Active low.
    logic mosi;
  } spi_pins_t;

  localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs: 1'b1, mosi: 1'b0};

  // Bus phases of one frame.
  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    SHIFT_CMD,
    SHIFT_READ,
    HOLD,
    GAP
  } engine_state_e;

endpackage

/* design/spi_cmd_stage.sv */
module spi_cmd_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [spi_cmd_pkg::CMD_W-1:0] cmd_in,
  input  logic                          cmd_vld,
  output logic                          cmd_rdy,
  output spi_cmd_pkg::cmd_t             job,
  output logic                          job_vld,
  input  logic                          job_take
);

  logic accept;

  assign cmd_rdy = !job_vld;                      // Buffer empty.
  assign accept  = cmd_vld && cmd_rdy;

  // Occupancy of the one-entry buffer.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      job_vld <= 1'b0;
    end
    else if (accept)
    begin
      job_vld <= 1'b1;
    end
    else if (job_take)
    begin
      job_vld <= 1'b0;
    end
  end

  // Split the raw word into its fields.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      job.write <= cmd_in[spi_cmd_pkg::CMD_W-1];
      job.addr  <= cmd_in[spi_cmd_pkg::CMD_W-2 -: spi_cmd_pkg::ADDR_W];
      job.wdata <= cmd_in[spi_cmd_pkg::DATA_W-1:0];   // Don't care on reads.
    end
  end

endmodule

/* design/spi_clk_gen.sv */
module spi_clk_gen #(
  parameter int CLK_DIV = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  output spi_bus_pkg::sclk_tick_t tick
);

  localparam int CNT_W = $clog2(CLK_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

  logic [CNT_W-1:0] cnt;
  logic             phase;                        // 0 means the next tick is a rise.
  logic             wrap;

  assign wrap = run && (cnt == '0);

  // Half-period counter that parks at reload while stopped.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt   <= CNT_LAST;
      phase <= 1'b0;
    end
    else if (!run)
    begin
      cnt   <= CNT_LAST;
      phase <= 1'b0;
    end
    else if (wrap)
    begin
      cnt   <= CNT_LAST;
      phase <= !phase;
    end
    else
    begin
      cnt <= cnt - 1'b1;
    end
  end

  assign tick.rise = wrap && !phase;
  assign tick.fall = wrap && phase;

endmodule

/* design/spi_shift_engine.sv */
module spi_shift_engine #(
  parameter int CLK_DIV = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  spi_cmd_pkg::cmd_t              job,
  input  logic                           job_vld,
  output logic                           job_take,
  output logic                           run,
  input  spi_bus_pkg::sclk_tick_t        tick,
  output spi_bus_pkg::spi_pins_t         pins,
  input  logic                           miso,
  output logic                           read_vld,
  output logic [spi_cmd_pkg::READ_W-1:0] read_data
);

  localparam int CMD_W     = spi_cmd_pkg::CMD_W;
  localparam int READ_W    = spi_cmd_pkg::READ_W;
  localparam int FRAME_MAX = CMD_W + READ_W;
  localparam int CNT_W     = $clog2(FRAME_MAX + 1);
  localparam int PH_W      = $clog2(CLK_DIV);
  localparam logic [PH_W-1:0] PH_LAST = PH_W'(CLK_DIV - 1);

  spi_bus_pkg::engine_state_e state;

  logic [PH_W-1:0]   phase_cnt;
  logic              phase_done;
  logic [CNT_W-1:0]  bit_cnt;                     // Rising edges issued so far.
  logic              is_read;
  logic              shifting;
  logic              frame_end;
  logic              sample_miso;
  logic              read_done;
  logic [CMD_W-1:0]  cmd_sr;
  logic [READ_W-1:0] rd_sr;

  assign job_take   = (state == spi_bus_pkg::IDLE) && job_vld;
  assign phase_done = (phase_cnt == '0);
  assign shifting   = (state == spi_bus_pkg::SHIFT_CMD) || (state == spi_bus_pkg::SHIFT_READ);
  assign frame_end  = bit_cnt == (is_read ? CNT_W'(FRAME_MAX) : CNT_W'(CMD_W));

  // The divider runs from SETUP on, so its first rise lands on the last SETUP cycle.
  assign run = (state == spi_bus_pkg::SETUP) || shifting;

  assign sample_miso = shifting && tick.rise && !frame_end && (bit_cnt >= CNT_W'(CMD_W));
  assign read_done   = (state == spi_bus_pkg::HOLD) && phase_done && is_read;

  // ******************************
  // Frame FSM
  // ******************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= spi_bus_pkg::IDLE;
      pins      <= spi_bus_pkg::PINS_IDLE;
      phase_cnt <= '0;
      bit_cnt   <= '0;
      is_read   <= 1'b0;
      read_vld  <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      if (!phase_done)
      begin
        phase_cnt <= phase_cnt - 1'b1;
      end

      case (state)
        spi_bus_pkg::IDLE:
        begin
          if (job_vld)
          begin
            state     <= spi_bus_pkg::SETUP;
            pins.cs   <= 1'b0;
            pins.mosi <= job.write;               // MSB goes out first.
            phase_cnt <= PH_LAST;
            bit_cnt   <= '0;
            is_read   <= (job.write == spi_cmd_pkg::CMD_READ);
          end
        end

        spi_bus_pkg::SETUP:
        begin
          if (phase_done)
          begin
            state     <= spi_bus_pkg::SHIFT_CMD;
            pins.sclk <= 1'b1;
            bit_cnt   <= CNT_W'(1);
          end
        end

        spi_bus_pkg::SHIFT_CMD, spi_bus_pkg::SHIFT_READ:
        begin
          if (tick.fall)
          begin
            pins.sclk <= 1'b0;
            pins.mosi <= cmd_sr[CMD_W-2];
          end
          else if (tick.rise)
          begin
            if (frame_end)
            begin
              // Last low half-period is over.
              state     <= spi_bus_pkg::HOLD;
              phase_cnt <= PH_LAST;
            end
            else
            begin
              pins.sclk <= 1'b1;
              bit_cnt   <= bit_cnt + 1'b1;
              if (bit_cnt == CNT_W'(CMD_W))
              begin
                state <= spi_bus_pkg::SHIFT_READ;
              end
            end
          end
        end

        spi_bus_pkg::HOLD:
        begin
          if (phase_done)
          begin
            state     <= spi_bus_pkg::GAP;
            pins.cs   <= 1'b1;
            phase_cnt <= PH_LAST;
            read_vld  <= is_read;
          end
        end

        spi_bus_pkg::GAP:
        begin
          if (phase_done)
          begin
            state <= spi_bus_pkg::IDLE;
          end
        end

        default:
        begin
          state <= spi_bus_pkg::IDLE;
        end
      endcase
    end
  end

  // ******************************
  // Data path
  // ******************************

  always_ff @(posedge clk)
  begin
    if (job_take)
    begin
      cmd_sr <= job;
    end
    else if (shifting && tick.fall)
    begin
      cmd_sr <= cmd_sr << 1;                      // Zeros follow the last bit.
    end

    if (sample_miso)
    begin
      rd_sr <= {rd_sr[READ_W-2:0], miso};
    end

    if (read_done)
    begin
      read_data <= rd_sr;                         // Held until the next read.
    end
  end

endmodule

/* design/spi_master_top.sv */
module spi_master_top #(
  parameter int CLK_DIV = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [spi_cmd_pkg::CMD_W-1:0]  cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic                           sclk,
  output logic                           cs,
  output logic                           mosi,
  input  logic                           miso,
  output logic                           read_vld,
  output logic [spi_cmd_pkg::READ_W-1:0] read_data
);

  spi_cmd_pkg::cmd_t       job;
  logic                    job_vld;
  logic                    job_take;
  logic                    run;
  spi_bus_pkg::sclk_tick_t tick;
  spi_bus_pkg::spi_pins_t  pins;

  spi_cmd_stage u_cmd_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .job      (job),
    .job_vld  (job_vld),
    .job_take (job_take)
  );

  spi_clk_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .tick  (tick)
  );

  spi_shift_engine #(
    .CLK_DIV (CLK_DIV)
  ) u_shift_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .job       (job),
    .job_vld   (job_vld),
    .job_take  (job_take),
    .run       (run),
    .tick      (tick),
    .pins      (pins),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  assign sclk = pins.sclk;
  assign cs   = pins.cs;
  assign mosi = pins.mosi;

endmodule

/* bench/spi_slave_model.sv */
module spi_slave_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  output int   frame_count,
  output logic frame_bad
);

  localparam int CMD_BITS  = 12;
  localparam int READ_BITS = 8;

  logic [7:0]          regs [8] = '{default: 8'h00};
  logic [CMD_BITS-1:0] cmd = '0;
  int                  nbits = 0;                 // Rising sclk edges in this frame.
  int                  expected_bits = 0;
  logic [2:0]          bit_idx;
  logic                miso_q = 1'b0;
  int                  count_q = 0;
  logic                bad_q = 1'b0;

  assign miso        = miso_q;
  assign frame_count = count_q;
  assign frame_bad   = bad_q;

  // Sample on rising sclk and close the frame when cs rises.
  always @(posedge sclk or posedge cs)
  begin
    if (!cs)
    begin
      if (nbits < CMD_BITS)
      begin
        cmd = {cmd[CMD_BITS-2:0], mosi};
      end
      nbits++;
    end
    else if (nbits != 0)
    begin
      expected_bits = cmd[CMD_BITS-1] ? CMD_BITS : CMD_BITS + READ_BITS;
      if (nbits != expected_bits)
      begin
        $display("Malformed frame: %0d sclk edges while %0d were due.", nbits, expected_bits);
        bad_q = 1'b1;
      end
      else
      begin
        if (cmd[CMD_BITS-1])
        begin
          regs[cmd[10:8]] = cmd[7:0];
        end
        count_q++;
      end
      nbits = 0;
      cmd   = '0;
    end
  end

  // Read data goes out MSB first with one bit per falling edge.
  always @(negedge sclk)
  begin
    if (!cs && nbits >= CMD_BITS && nbits < CMD_BITS + READ_BITS)
    begin
      bit_idx = 3'(CMD_BITS + READ_BITS - 1 - nbits);
      miso_q  = regs[cmd[10:8]][bit_idx];
    end
    else
    begin
      miso_q = 1'b0;
    end
  end

endmodule

/* bench/tb_spi_master.sv */
module tb_spi_master;

  localparam int CLK_DIV      = 4;
  localparam int CMD_BITS     = 12;
  localparam int READ_BITS    = 8;
  localparam int RDY_TIMEOUT  = 500;              // Cycles.
  localparam int DONE_TIMEOUT = 2000;

  typedef struct packed {
    logic                          write;
    logic [spi_cmd_pkg::READ_W-1:0] rdata;
  } frame_exp_t;

  logic                          clk;
  logic                          rst_n;
  logic [spi_cmd_pkg::CMD_W-1:0] cmd_in;
  logic                          cmd_vld;
  logic                          cmd_rdy;
  logic                          sclk;
  logic                          cs;
  logic                          mosi;
  logic                          miso;
  logic                          read_vld;
  logic [spi_cmd_pkg::READ_W-1:0] read_data;
  int                            frame_count;
  logic                          frame_bad;

  logic [7:0]  shadow [8] = '{default: 8'h00};    // Expected register contents.
  frame_exp_t  exp_q [$];
  logic [15:0] lfsr = 16'd31;
  int          issued = 0;
  logic        cs_prev = 1'b1;
  logic        sclk_prev = 1'b0;
  int          low_cycles = 0;
  int          high_cycles = 0;
  int          rises = 0;
  int          last_rises = 0;
  int          last_low = 0;
  int          read_pulses = 0;

  spi_master_top #(
    .CLK_DIV (CLK_DIV)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso),
    .frame_count (frame_count),
    .frame_bad   (frame_bad)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ******************************
  // Helpers
  // ******************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
    else abort_run($sformatf("MISMATCH at %0t: %s expected 0x%0h, got 0x%0h",
                             $time, name, expected, actual));
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_random(input int nbits, output logic [7:0] value);
    int i;
    value = '0;
    for (i = 0; i < nbits; i++)
    begin
      lfsr  = lfsr_step(lfsr);                    // One step per bit.
      value = {value[6:0], lfsr[0]};
    end
  endtask

  // Called at edge + 5 and returns at edge + 5 after the transfer edge.
  task automatic issue_cmd(input logic write, input logic [2:0] addr, input logic [7:0] data);
    spi_cmd_pkg::cmd_t c;
    frame_exp_t        fe;
    int                waited;
    waited  = 0;
    c.write = write;
    c.addr  = addr;
    c.wdata = data;
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      @(posedge clk);
      #5;
      waited++;
      assert (waited < RDY_TIMEOUT) else abort_run("cmd_rdy never came back high.");
    end
    @(posedge clk);
    #5;
    cmd_vld  = 1'b0;
    fe.write = write;
    fe.rdata = shadow[addr];
    if (write)
    begin
      shadow[addr] = data;
    end
    exp_q.push_back(fe);
    issued++;
  endtask

  task automatic wait_all_done();
    int waited;
    waited = 0;
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #5;
      waited++;
      assert (waited < DONE_TIMEOUT) else abort_run("A frame never finished, cs did not rise.");
    end
  endtask

  task automatic close_frame();
    frame_exp_t fe;
    if (exp_q.size() == 0)
    begin
      abort_run("cs rose with no command outstanding.");
    end
    else
    begin
      fe         = exp_q.pop_front();
      last_rises = rises;
      last_low   = low_cycles;
      expect_equal("read_vld", 32'(!fe.write), 32'(read_vld));   // Pulse with cs rise.
      if (!fe.write)
      begin
        expect_equal("read_data", 32'(fe.rdata), 32'(read_data));
      end
    end
  endtask

  // ******************************
  // Bus monitor
  // ******************************

  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      cs_prev     = 1'b1;
      sclk_prev   = 1'b0;
      high_cycles = CLK_DIV;
    end
    else
    begin
      assert (!frame_bad) else abort_run("The slave model received a malformed frame.");
      if (cs && !cs_prev)
      begin
        close_frame();
      end
      else
      begin
        expect_equal("read_vld", 0, 32'(read_vld));
      end
      if (!cs && cs_prev)
      begin
        assert (high_cycles >= CLK_DIV) else abort_run("cs went low again too soon.");
        low_cycles = 0;
        rises      = 0;
      end
      if (!cs)
      begin
        low_cycles++;
        if (sclk && !sclk_prev)
        begin
          rises++;
        end
      end
      if (read_vld)
      begin
        read_pulses++;
      end
      high_cycles = cs ? high_cycles + 1 : 0;
      cs_prev     = cs;
      sclk_prev   = sclk;
    end
  end

  // ******************************
  // Directed tests
  // ******************************

  task automatic check_reset_state();
    expect_equal("cs", 1, 32'(cs));
    expect_equal("sclk", 0, 32'(sclk));
    expect_equal("mosi", 0, 32'(mosi));
    expect_equal("read_vld", 0, 32'(read_vld));
    expect_equal("cmd_rdy", 1, 32'(cmd_rdy));
  endtask

  task automatic write_then_read();
    logic [7:0] data;
    int         pulses_before;
    take_random(8, data);
    issue_cmd(1'b1, 3'd5, data);
    pulses_before = read_pulses;
    issue_cmd(1'b0, 3'd5, 8'h00);
    wait_all_done();
    expect_equal("read_vld pulses", 1, read_pulses - pulses_before);
  endtask

  task automatic sweep_registers();
    logic [7:0] data;
    int         a;
    for (a = 0; a < 8; a++)
    begin
      issue_cmd(1'b0, 3'(a), 8'h00);              // Mostly unwritten so far.
    end
    for (a = 0; a < 8; a++)
    begin
      take_random(8, data);
      issue_cmd(1'b1, 3'(a), data);
    end
    for (a = 0; a < 8; a++)
    begin
      issue_cmd(1'b0, 3'(a), 8'h00);
    end
    wait_all_done();
  endtask

  task automatic run_back_to_back();
    logic [7:0] r;
    logic [7:0] data;
    logic       write;
    logic [2:0] addr;
    int         i;
    for (i = 0; i < 12; i++)
    begin
      take_random(1, r);
      write = r[0];
      take_random(3, r);
      addr = r[2:0];
      take_random(8, data);
      issue_cmd(write, addr, data);
    end
    wait_all_done();
    expect_equal("frame_count", issued, frame_count);
  endtask

  task automatic check_frame_shape();
    issue_cmd(1'b1, 3'd2, 8'hA5);
    wait_all_done();
    expect_equal("sclk rises", CMD_BITS, last_rises);
    expect_equal("cs low cycles", (2 + 2 * CMD_BITS) * CLK_DIV, last_low);
    issue_cmd(1'b0, 3'd2, 8'h00);
    wait_all_done();
    expect_equal("sclk rises", CMD_BITS + READ_BITS, last_rises);
    expect_equal("cs low cycles", (2 + 2 * (CMD_BITS + READ_BITS)) * CLK_DIV, last_low);
  endtask

  initial
  begin
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    repeat (8) @(posedge clk);
    #5;
    rst_n = 1'b1;
    check_reset_state();
    write_then_read();
    sweep_registers();
    run_back_to_back();
    check_frame_shape();
    $display("Test OK");
    $finish;
  end

endmodule

/* files.f */
design/spi_cmd_pkg.sv
design/spi_bus_pkg.sv
design/spi_cmd_stage.sv
design/spi_clk_gen.sv
design/spi_shift_engine.sv
design/spi_master_top.sv
bench/spi_slave_model.sv
bench/tb_spi_master.sv

/* Makefile */
# Verilator build and run for the SPI master testbench.

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR, TOP, FILELIST, OBJ_DIR, VFLAGS"

# The run's exit status decides pass or fail.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
